// File: verilog.f
design/accel_ctrl_pkg.sv
design/ctrl_config.sv
design/tile_sequencer.sv
design/ifm_buffer_ctrl.sv
design/wgt_shift_skew.sv
design/output_write_ctrl.sv
design/accel_ctrl_top.sv
verif/accel_ctrl_properties.sv
verif/accel_ctrl_tb.sv

// File: Bender.yml
package:
  name: accel_ctrl

sources:
  - design/accel_ctrl_pkg.sv
  - design/ctrl_config.sv
  - design/tile_sequencer.sv
  - design/ifm_buffer_ctrl.sv
  - design/wgt_shift_skew.sv
  - design/output_write_ctrl.sv
  - design/accel_ctrl_top.sv
  - target: simulation
    files:
      - verif/accel_ctrl_properties.sv
      - verif/accel_ctrl_tb.sv

// File: verif/accel_ctrl_tb.sv
`timescale 1ns/1ps

module accel_ctrl_tb;

    localparam int S = 4;
    localparam int K = 3;
    localparam int IC = 1;
    localparam int OFM = 4;
    localparam int L = K * K * IC;
    localparam int C = L + 2 * S - 1;
    localparam int T = ((OFM + S - 1) / S) * OFM;
    localparam int GROUP_LEN = L + T * C + S;
    localparam int NUM_ROWS = 5;
    localparam int MAX_GAP = 17;

    typedef struct {
        logic [4:0] wgt;
        logic [3:0] groups;
        bit         busy_start;
        int         cycles;
        int         load_wgt;
        int         pe;
        int         pool;
        int         demux;
    } run_row_t;

    logic         clk = 1'b0;
    logic         rst_n;
    logic         start;
    logic [4:0]   wgt_size;
    logic [3:0]   filter_groups;
    logic         load_ifm, ifm_demux, ifm_mux, ifm_shift_en_1, ifm_shift_en_2;
    logic         load_wgt, select_wgt, reset_pe, done;
    logic [S-1:0] wgt_shift_en;
    logic         write_out_pe_en, write_out_maxpool_en, fifo_wr_en, fifo_rd_en;
    logic [3:0]   filter_group;

    run_row_t     rows [NUM_ROWS];
    logic [15:0]  lfsr_state = 16'd21503;
    int           errors = 0;
    int           cycle_count = 0;
    int           cycle_limit = 100000;
    int           done_pulses = 0;
    bit           measuring = 0;
    bit           run_over = 0;
    bit           first_sample;
    logic         prev_demux;
    logic [S-1:0] prev_shift;
    int           high_len [S];
    int           bit0_rise;
    int           run_cycles, load_wgt_cycles, pe_cycles, wr_cycles, rd_cycles, pool_cycles;
    int           demux_changes, shift_rises;

    always #10 clk = ~clk;

    accel_ctrl_top #(
        .SYSTOLIC_SIZE (S),
        .KERNEL_SIZE   (K),
        .IFM_CHANNEL   (IC),
        .OFM_SIZE      (OFM)
    ) i_accel_ctrl_top (
        .clk                  (clk),
        .rst_n                (rst_n),
        .start                (start),
        .wgt_size             (wgt_size),
        .filter_groups        (filter_groups),
        .load_ifm             (load_ifm),
        .ifm_demux            (ifm_demux),
        .ifm_mux              (ifm_mux),
        .ifm_shift_en_1       (ifm_shift_en_1),
        .ifm_shift_en_2       (ifm_shift_en_2),
        .load_wgt             (load_wgt),
        .select_wgt           (select_wgt),
        .wgt_shift_en         (wgt_shift_en),
        .reset_pe             (reset_pe),
        .write_out_pe_en      (write_out_pe_en),
        .write_out_maxpool_en (write_out_maxpool_en),
        .fifo_wr_en           (fifo_wr_en),
        .fifo_rd_en           (fifo_rd_en),
        .filter_group         (filter_group),
        .done                 (done)
    );

    bind accel_ctrl_top accel_ctrl_properties #(
        .SYSTOLIC_SIZE (SYSTOLIC_SIZE)
    ) i_accel_ctrl_properties (
        .clk            (clk),
        .rst_n          (rst_n),
        .phase          (phase),
        .ifm_shift_en_1 (ifm_shift_en_1),
        .ifm_shift_en_2 (ifm_shift_en_2),
        .load_ifm       (load_ifm),
        .load_wgt       (load_wgt),
        .wgt_shift_en   (wgt_shift_en),
        .pe_en          (write_out_pe_en),
        .fifo_wr_en     (fifo_wr_en),
        .fifo_rd_en     (fifo_rd_en),
        .done           (done)
    );

    task automatic check_value(input string name, input int expected, input int actual);
        if (expected !== actual) begin
            errors++;
            $display("[ERROR] %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    function automatic run_row_t make_row(input int wgt, input int groups, input int cols,
                                          input bit busy_start);
        run_row_t r;
        r.wgt        = 5'(wgt);
        r.groups     = 4'(groups);
        r.busy_start = busy_start;
        r.cycles     = groups * GROUP_LEN;
        r.load_wgt   = groups * L;
        r.pe         = groups * T * cols;
        r.pool       = groups * (T / 2) * cols; // every second row pools.
        r.demux      = groups * (T - 1);
        return r;
    endfunction

    // 16-bit fibonacci lfsr, taps 16 14 13 11.
    function automatic int draw_random_bits(input int n);
        int value;
        value = 0;
        for (int b = 0; b < n; b++) begin
            lfsr_state = {lfsr_state[14:0],
                          lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10]};
            value = (value << 1) | int'(lfsr_state[0]);
        end
        return value;
    endfunction

    task automatic check_idle_outputs();
        check_value("idle strobes", 13'b0010001000000,
                    {load_ifm, ifm_demux, ifm_mux, ifm_shift_en_1, ifm_shift_en_2, load_wgt,
                     select_wgt, reset_pe, write_out_pe_en, write_out_maxpool_en, fifo_wr_en,
                     fifo_rd_en, done});
        check_value("idle wgt_shift_en", 0, wgt_shift_en);
        check_value("idle filter_group", 0, filter_group);
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("TEST FAIL");
            $finish;
        end
    end

    always @(negedge clk) begin
        if (done) done_pulses++;
        if (measuring) begin
            run_cycles++;
            if (load_wgt) load_wgt_cycles++;
            if (write_out_pe_en) pe_cycles++;
            if (fifo_wr_en) wr_cycles++;
            if (fifo_rd_en) rd_cycles++;
            if (write_out_maxpool_en) pool_cycles++;
            if (!first_sample && ifm_demux != prev_demux) demux_changes++;
            for (int i = 0; i < S; i++) begin
                if (wgt_shift_en[i]) begin
                    if (!prev_shift[i]) begin
                        shift_rises++;
                        if (i == 0) begin
                            bit0_rise = run_cycles;
                        end else begin
                            check_value("wgt_shift_en skew", i, run_cycles - bit0_rise);
                        end
                    end
                    high_len[i]++;
                end else if (prev_shift[i]) begin
                    check_value("wgt_shift_en width", L, high_len[i]);
                    high_len[i] = 0;
                end
            end
            prev_shift   = wgt_shift_en;
            prev_demux   = ifm_demux;
            first_sample = 0;
            if (done) begin
                measuring = 0;
                run_over  = 1;
            end
        end
    end

    initial begin
        int gap;
        int asserts;
        rst_n         = 1'b0;
        start         = 1'b0;
        wgt_size      = '0;
        filter_groups = '0;
        rows[0] = make_row(0, 1, 1, 0); // clamped up to one column.
        rows[1] = make_row(3, 2, 3, 0);
        rows[2] = make_row(4, 3, 4, 0);
        rows[3] = make_row(9, 1, 4, 1); // clamped down to the array width.
        rows[4] = make_row(3, 2, 3, 1);
        cycle_limit = 10 + 100;
        foreach (rows[r]) cycle_limit += rows[r].cycles + MAX_GAP + 2;
        repeat (5) @(negedge clk);
        check_idle_outputs();
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_idle_outputs();
        foreach (rows[r]) begin
            gap = draw_random_bits(4);
            repeat (gap + 2) @(posedge clk);
            wgt_size      <= rows[r].wgt;
            filter_groups <= rows[r].groups;
            start         <= 1'b1;
            @(posedge clk);
            start <= 1'b0;
            run_cycles      = 0;
            load_wgt_cycles = 0;
            pe_cycles       = 0;
            wr_cycles       = 0;
            rd_cycles       = 0;
            pool_cycles     = 0;
            demux_changes   = 0;
            shift_rises     = 0;
            prev_shift   = '0;
            high_len     = '{default: 0};
            first_sample = 1;
            run_over     = 0;
            measuring    = 1;
            if (rows[r].busy_start) begin
                repeat (30) @(posedge clk);
                wgt_size      <= 5'd1;
                filter_groups <= 4'd7;
                start         <= 1'b1;
                @(posedge clk);
                start <= 1'b0;
            end
            while (!run_over) @(posedge clk);
            check_value("run length", rows[r].cycles, run_cycles);
            check_value("load_wgt cycles", rows[r].load_wgt, load_wgt_cycles);
            check_value("write_out_pe_en cycles", rows[r].pe, pe_cycles);
            check_value("fifo_wr_en cycles", rows[r].pool, wr_cycles);
            check_value("fifo_rd_en cycles", rows[r].pool, rd_cycles);
            check_value("write_out_maxpool_en cycles", rows[r].pool, pool_cycles);
            check_value("ifm_demux changes", rows[r].demux, demux_changes);
            check_value("wgt_shift_en rises", rows[r].groups * T * S, shift_rises);
        end
        repeat (5) @(posedge clk);
        check_value("done pulses", NUM_ROWS, done_pulses);
        asserts = i_accel_ctrl_top.i_accel_ctrl_properties.fail_count;
        $display("errors: %0d check, %0d assertion", errors, asserts);
        if (errors == 0 && asserts == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: verif/accel_ctrl_properties.sv
`timescale 1ns/1ps

module accel_ctrl_properties #(
    parameter int SYSTOLIC_SIZE = 16
) (
    input logic                         clk,
    input logic                         rst_n,
    input accel_ctrl_pkg::phase_t       phase,
    input logic                         ifm_shift_en_1,
    input logic                         ifm_shift_en_2,
    input logic                         load_ifm,
    input logic                         load_wgt,
    input logic [SYSTOLIC_SIZE-1:0]     wgt_shift_en,
    input logic                         pe_en,
    input logic                         fifo_wr_en,
    input logic                         fifo_rd_en,
    input logic                         done
);
    import accel_ctrl_pkg::*;

    int fail_count = 0;

    // one buffer always shifts while a tile is in flight.
    ifm_one_off: assert property (@(posedge clk) disable iff (!rst_n)
        phase inside {LOAD_WEIGHT, LOAD_COMPUTE, LOAD_COMPUTE_WRITE, COMPUTE_WRITE}
        |-> (ifm_shift_en_1 || ifm_shift_en_2))
        else begin
            fail_count++;
            $error("both ifm shift enables low in phase %s", phase.name());
        end

    fifo_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(fifo_wr_en && fifo_rd_en))
        else begin
            fail_count++;
            $error("fifo write and read high together");
        end

    done_single: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(done) |=> !done)
        else begin
            fail_count++;
            $error("done held longer than one cycle");
        end

    idle_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        (phase == IDLE) |-> (wgt_shift_en == '0 && !pe_en && !fifo_wr_en && !fifo_rd_en
                             && !load_ifm && !load_wgt))
        else begin
            fail_count++;
            $error("control strobe active while idle");
        end

endmodule

// File: design/accel_ctrl_top.sv
`timescale 1ns/1ps

module accel_ctrl_top #(
    parameter int SYSTOLIC_SIZE = 16,
    parameter int KERNEL_SIZE   = 3,
    parameter int IFM_CHANNEL   = 3,
    parameter int OFM_SIZE      = 32
) (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               start,
    input  logic [accel_ctrl_pkg::COL_W-1:0]   wgt_size,
    input  logic [accel_ctrl_pkg::GROUP_W-1:0] filter_groups,
    output logic                               load_ifm,
    output logic                               ifm_demux,
    output logic                               ifm_mux,
    output logic                               ifm_shift_en_1,
    output logic                               ifm_shift_en_2,
    output logic                               load_wgt,
    output logic                               select_wgt,
    output logic [SYSTOLIC_SIZE-1:0]           wgt_shift_en,
    output logic                               reset_pe,
    output logic                               write_out_pe_en,
    output logic                               write_out_maxpool_en,
    output logic                               fifo_wr_en,
    output logic                               fifo_rd_en,
    output logic [accel_ctrl_pkg::GROUP_W-1:0] filter_group,
    output logic                               done
);
    import accel_ctrl_pkg::*;

    logic [COL_W-1:0]   cfg_wgt_size;
    logic [GROUP_W-1:0] cfg_groups;
    logic               busy;
    phase_t             phase;
    logic [COUNT_W-1:0] phase_count;

    ctrl_config #(
        .SYSTOLIC_SIZE (SYSTOLIC_SIZE)
    ) i_ctrl_config (
        .clk           (clk),
        .rst_n         (rst_n),
        .start         (start),
        .wgt_size      (wgt_size),
        .filter_groups (filter_groups),
        .done          (done),
        .cfg_wgt_size  (cfg_wgt_size),
        .cfg_groups    (cfg_groups),
        .busy          (busy)
    );

    tile_sequencer #(
        .SYSTOLIC_SIZE (SYSTOLIC_SIZE),
        .KERNEL_SIZE   (KERNEL_SIZE),
        .IFM_CHANNEL   (IFM_CHANNEL),
        .OFM_SIZE      (OFM_SIZE)
    ) i_tile_sequencer (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .busy         (busy),
        .cfg_groups   (cfg_groups),
        .phase        (phase),
        .phase_count  (phase_count),
        .filter_group (filter_group),
        .done         (done)
    );

    ifm_buffer_ctrl #(
        .SYSTOLIC_SIZE (SYSTOLIC_SIZE),
        .KERNEL_SIZE   (KERNEL_SIZE),
        .IFM_CHANNEL   (IFM_CHANNEL)
    ) i_ifm_buffer_ctrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .phase          (phase),
        .phase_count    (phase_count),
        .load_ifm       (load_ifm),
        .ifm_demux      (ifm_demux),
        .ifm_mux        (ifm_mux),
        .ifm_shift_en_1 (ifm_shift_en_1),
        .ifm_shift_en_2 (ifm_shift_en_2)
    );

    wgt_shift_skew #(
        .SYSTOLIC_SIZE (SYSTOLIC_SIZE),
        .KERNEL_SIZE   (KERNEL_SIZE),
        .IFM_CHANNEL   (IFM_CHANNEL)
    ) i_wgt_shift_skew (
        .phase        (phase),
        .phase_count  (phase_count),
        .load_wgt     (load_wgt),
        .select_wgt   (select_wgt),
        .wgt_shift_en (wgt_shift_en),
        .reset_pe     (reset_pe)
    );

    output_write_ctrl i_output_write_ctrl (
        .clk                  (clk),
        .rst_n                (rst_n),
        .phase                (phase),
        .phase_count          (phase_count),
        .cfg_wgt_size         (cfg_wgt_size),
        .write_out_pe_en      (write_out_pe_en),
        .write_out_maxpool_en (write_out_maxpool_en),
        .fifo_wr_en           (fifo_wr_en),
        .fifo_rd_en           (fifo_rd_en)
    );

endmodule

// File: design/output_write_ctrl.sv
`timescale 1ns/1ps

module output_write_ctrl (
    input  logic                               clk,
    input  logic                               rst_n,
    input  accel_ctrl_pkg::phase_t             phase,
    input  logic [accel_ctrl_pkg::COUNT_W-1:0] phase_count,
    input  logic [accel_ctrl_pkg::COL_W-1:0]   cfg_wgt_size,
    output logic                               write_out_pe_en,
    output logic                               write_out_maxpool_en,
    output logic                               fifo_wr_en,
    output logic                               fifo_rd_en
);
    import accel_ctrl_pkg::*;

    logic [COUNT_W-1:0] cols;
    logic               wnd_open;
    logic               wnd_last;
    logic               pool_odd;

    assign cols = COUNT_W'(cfg_wgt_size);

    // one window per finished tile.
    assign wnd_open = (phase inside {LOAD_COMPUTE_WRITE, COMPUTE_WRITE, WRITE}) &&
                      (phase_count < cols);
    assign wnd_last = wnd_open && (phase_count == cols - COUNT_W'(1));

    // even rows go to the line FIFO, odd rows pool against them.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pool_odd <= 1'b0;
        end else if (phase == LOAD_WEIGHT) begin
            pool_odd <= 1'b0;
        end else if (wnd_last) begin
            pool_odd <= ~pool_odd;
        end
    end

    assign write_out_pe_en      = wnd_open;
    assign fifo_wr_en           = wnd_open && !pool_odd;
    assign fifo_rd_en           = wnd_open && pool_odd;
    assign write_out_maxpool_en = wnd_open && pool_odd; // pooled pair ready.

endmodule

// File: design/wgt_shift_skew.sv
`timescale 1ns/1ps

module wgt_shift_skew #(
    parameter int SYSTOLIC_SIZE = 16,
    parameter int KERNEL_SIZE   = 3,
    parameter int IFM_CHANNEL   = 3
) (
    input  accel_ctrl_pkg::phase_t             phase,
    input  logic [accel_ctrl_pkg::COUNT_W-1:0] phase_count,
    output logic                               load_wgt,
    output logic                               select_wgt,
    output logic [SYSTOLIC_SIZE-1:0]           wgt_shift_en,
    output logic                               reset_pe
);
    import accel_ctrl_pkg::*;

    localparam int L = KERNEL_SIZE * KERNEL_SIZE * IFM_CHANNEL;
    localparam int C = L + 2 * SYSTOLIC_SIZE - 1;

    localparam logic [COUNT_W-1:0] LOAD_LEN  = COUNT_W'(L);
    localparam logic [COUNT_W-1:0] COMP_LAST = COUNT_W'(C - 1);

    logic computing;

    assign computing = phase inside {LOAD_COMPUTE, LOAD_COMPUTE_WRITE, COMPUTE_WRITE};

    assign load_wgt   = (phase == LOAD_WEIGHT) && (phase_count < LOAD_LEN);
    assign select_wgt = phase inside {IDLE, LOAD_WEIGHT};

    // row i starts i cycles late, matching the input skew.
    always_comb begin
        for (int i = 0; i < SYSTOLIC_SIZE; i++) begin
            wgt_shift_en[i] = computing &&
                              (phase_count >= COUNT_W'(i)) &&
                              (phase_count < COUNT_W'(L + i));
        end
    end

    // clear accumulators once the partial sums are drained.
    assign reset_pe = (computing && phase_count == COMP_LAST) || (phase == WRITE);

endmodule

// File: design/ifm_buffer_ctrl.sv
`timescale 1ns/1ps

module ifm_buffer_ctrl #(
    parameter int SYSTOLIC_SIZE = 16,
    parameter int KERNEL_SIZE   = 3,
    parameter int IFM_CHANNEL   = 3
) (
    input  logic                               clk,
    input  logic                               rst_n,
    input  accel_ctrl_pkg::phase_t             phase,
    input  logic [accel_ctrl_pkg::COUNT_W-1:0] phase_count,
    output logic                               load_ifm,
    output logic                               ifm_demux,
    output logic                               ifm_mux,
    output logic                               ifm_shift_en_1,
    output logic                               ifm_shift_en_2
);
    import accel_ctrl_pkg::*;

    localparam int L = KERNEL_SIZE * KERNEL_SIZE * IFM_CHANNEL;
    localparam int C = L + 2 * SYSTOLIC_SIZE - 1;

    localparam logic [COUNT_W-1:0] LOAD_LEN  = COUNT_W'(L);
    localparam logic [COUNT_W-1:0] FILL_LEN  = COUNT_W'(L + 2);
    localparam logic [COUNT_W-1:0] COMP_LAST = COUNT_W'(C - 1);

    logic buf_sel;
    logic loading;
    logic computing;
    logic fill_on;

    assign loading   = phase inside {LOAD_WEIGHT, LOAD_COMPUTE, LOAD_COMPUTE_WRITE};
    assign computing = phase inside {LOAD_COMPUTE, LOAD_COMPUTE_WRITE, COMPUTE_WRITE};
    assign fill_on   = loading && (phase_count < FILL_LEN); // two extra shifts to settle.

    // toggles on the last count so the swap shows at count 0.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            buf_sel <= 1'b0;
        end else if (phase == IDLE) begin
            buf_sel <= 1'b0;
        end else if (phase inside {LOAD_COMPUTE, LOAD_COMPUTE_WRITE} &&
                     phase_count == COMP_LAST) begin
            buf_sel <= ~buf_sel;
        end
    end

    assign load_ifm  = loading && (phase_count < LOAD_LEN);
    assign ifm_demux = buf_sel;  // buffer being filled.
    assign ifm_mux   = ~buf_sel; // buffer feeding the array.

    // feeding buffer shifts the whole phase.
    assign ifm_shift_en_1 = buf_sel ? computing : fill_on;
    assign ifm_shift_en_2 = buf_sel ? fill_on : computing;

endmodule

// File: design/tile_sequencer.sv
`timescale 1ns/1ps

module tile_sequencer #(
    parameter int SYSTOLIC_SIZE = 16,
    parameter int KERNEL_SIZE   = 3,
    parameter int IFM_CHANNEL   = 3,
    parameter int OFM_SIZE      = 32
) (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               start,
    input  logic                               busy,
    input  logic [accel_ctrl_pkg::GROUP_W-1:0] cfg_groups,
    output accel_ctrl_pkg::phase_t             phase,
    output logic [accel_ctrl_pkg::COUNT_W-1:0] phase_count,
    output logic [accel_ctrl_pkg::GROUP_W-1:0] filter_group,
    output logic                               done
);
    import accel_ctrl_pkg::*;

    localparam int L        = KERNEL_SIZE * KERNEL_SIZE * IFM_CHANNEL;
    localparam int C        = L + 2 * SYSTOLIC_SIZE - 1;
    localparam int T        = ((OFM_SIZE + SYSTOLIC_SIZE - 1) / SYSTOLIC_SIZE) * OFM_SIZE;
    localparam int LCW_REPS = T - 2;
    localparam int TILE_W   = $clog2(T + 1);

    localparam logic [COUNT_W-1:0] LOAD_LAST  = COUNT_W'(L - 1);
    localparam logic [COUNT_W-1:0] COMP_LAST  = COUNT_W'(C - 1);
    localparam logic [COUNT_W-1:0] WRITE_LAST = COUNT_W'(SYSTOLIC_SIZE - 1);

    phase_t             phase_next;
    logic [COUNT_W-1:0] count_last;
    logic               phase_end;
    logic               last_group;
    logic [TILE_W-1:0]  tile_count;

    always_comb begin
        case (phase)
            LOAD_WEIGHT: count_last = LOAD_LAST;
            WRITE:       count_last = WRITE_LAST;
            default:     count_last = COMP_LAST;
        endcase
    end

    assign phase_end  = (phase_count == count_last);
    assign last_group = (filter_group == cfg_groups - GROUP_W'(1));
    assign done       = (phase == WRITE) && phase_end && last_group;

    always_comb begin
        phase_next = phase;
        case (phase)
            IDLE: begin
                if (start && !busy) phase_next = LOAD_WEIGHT;
            end
            LOAD_WEIGHT: begin
                if (phase_end) phase_next = LOAD_COMPUTE;
            end
            LOAD_COMPUTE: begin
                if (phase_end) begin
                    phase_next = (LCW_REPS > 0) ? LOAD_COMPUTE_WRITE : COMPUTE_WRITE;
                end
            end
            LOAD_COMPUTE_WRITE: begin
                // last overlapped tile goes on to the drain phase.
                if (phase_end && tile_count == TILE_W'(LCW_REPS - 1)) begin
                    phase_next = COMPUTE_WRITE;
                end
            end
            COMPUTE_WRITE: begin
                if (phase_end) phase_next = WRITE;
            end
            WRITE: begin
                if (phase_end) phase_next = last_group ? IDLE : LOAD_WEIGHT;
            end
            default: phase_next = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase        <= IDLE;
            phase_count  <= '0;
            tile_count   <= '0;
            filter_group <= '0;
        end else begin
            phase <= phase_next;
            if (phase == IDLE || phase_end) begin
                phase_count <= '0; // restarts every phase.
            end else begin
                phase_count <= phase_count + COUNT_W'(1);
            end
            if (phase == LOAD_COMPUTE) begin
                tile_count <= '0;
            end else if (phase == LOAD_COMPUTE_WRITE && phase_end) begin
                tile_count <= tile_count + TILE_W'(1);
            end
            if (phase == IDLE) begin
                filter_group <= '0;
            end else if (phase == WRITE && phase_end && !last_group) begin
                filter_group <= filter_group + GROUP_W'(1); // next group.
            end
        end
    end

endmodule

// File: design/ctrl_config.sv
`timescale 1ns/1ps

module ctrl_config #(
    parameter int SYSTOLIC_SIZE = 16
) (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               start,
    input  logic [accel_ctrl_pkg::COL_W-1:0]   wgt_size,
    input  logic [accel_ctrl_pkg::GROUP_W-1:0] filter_groups,
    input  logic                               done,
    output logic [accel_ctrl_pkg::COL_W-1:0]   cfg_wgt_size,
    output logic [accel_ctrl_pkg::GROUP_W-1:0] cfg_groups,
    output logic                               busy
);
    import accel_ctrl_pkg::*;

    localparam logic [COL_W-1:0] MAX_COLS = COL_W'(SYSTOLIC_SIZE);

    logic [COL_W-1:0]   cols_clamped;
    logic [GROUP_W-1:0] groups_clamped;

    always_comb begin
        if (wgt_size == '0) begin
            cols_clamped = COL_W'(1);
        end else if (wgt_size > MAX_COLS) begin
            cols_clamped = MAX_COLS; // never wider than the array.
        end else begin
            cols_clamped = wgt_size;
        end
        groups_clamped = (filter_groups == '0) ? GROUP_W'(1) : filter_groups;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy         <= 1'b0;
            cfg_wgt_size <= '0;
            cfg_groups   <= '0;
        end else if (start && !busy) begin
            busy         <= 1'b1;
            cfg_wgt_size <= cols_clamped;
            cfg_groups   <= groups_clamped;
        end else if (done) begin
            busy         <= 1'b0; // run over, drop config.
            cfg_wgt_size <= '0;
            cfg_groups   <= '0;
        end
    end

endmodule

// File: design/accel_ctrl_pkg.sv
package accel_ctrl_pkg;

    // phase counter width, covers the longest compute phase.
    localparam int COUNT_W = 13;

    // filter group count and index.
    localparam int GROUP_W = 4;

    // valid output columns per row.
    localparam int COL_W = 5;

    typedef enum logic [2:0] {
        IDLE               = 3'd0,
        LOAD_WEIGHT        = 3'd1,
        LOAD_COMPUTE       = 3'd2,
        LOAD_COMPUTE_WRITE = 3'd3,
        COMPUTE_WRITE      = 3'd4,
        WRITE              = 3'd5
    } phase_t;

endpackage
